/* src/vl53_regs_pkg.sv */
package vl53_regs_pkg;

	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] ram_addr_t;

	////////////////////
	// sensor registers
	////////////////////

	// range start and sequence step enables
	localparam reg_addr_t SYSRANGE_START = 8'h00;
	localparam reg_addr_t SYSTEM_SEQUENCE_CONFIG = 8'h01;

	// signal rate limit, 9.7 fixed point MCPS
	localparam reg_addr_t FINAL_RANGE_CONFIG_MIN_COUNT_RATE_RTN_LIMIT = 8'h44;

	// limit check enables
	localparam reg_addr_t MSRC_CONFIG_CONTROL = 8'h60;

	localparam reg_addr_t POWER_MANAGEMENT_GO1_POWER_FORCE = 8'h80;

	// i2c standard mode select
	localparam reg_addr_t I2C_MODE_CTRL = 8'h88;

	// pad supply, bit 0 selects 2v8 io
	localparam reg_addr_t VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV = 8'h89;

	// holds the stop variable while the private page is open
	localparam reg_addr_t STOP_VARIABLE_SRC = 8'h91;

	// private register page
	localparam reg_addr_t PAGE_SELECT = 8'hFF;

	////////////////////
	// ram variables
	////////////////////

	// shared with later init phases
	localparam ram_addr_t STOP_VARIABLE = 8'h00;

endpackage

/* src/init_seq_pkg.sv */
package init_seq_pkg;
	import vl53_regs_pkg::*;

	typedef logic [7:0] byte_t;
	typedef logic [3:0] n_bytes_t;

	// transaction codes seen by the i2c engine
	typedef logic [1:0] fnc_t;
	localparam fnc_t FNC_READ = 2'd1;
	localparam fnc_t FNC_WRITE = 2'd2;
	localparam fnc_t FNC_WRITE_MULTI = 2'd3;

	// modify and capture both go to the read-back engine
	typedef enum logic [1:0] {STEP_MODIFY, STEP_CAPTURE, STEP_TABLE, STEP_MULTI} step_kind_t;

	// arg is the or-mask, the ram address or the table start index
	typedef struct packed {
		step_kind_t kind;
		reg_addr_t reg_addr;
		byte_t arg;
		n_bytes_t count;
	} step_t;

	typedef struct packed {
		reg_addr_t addr;
		byte_t data;
	} table_entry_t;

	localparam int STEP_COUNT = 7;
	localparam int STEP_IDX_W = $clog2(STEP_COUNT);
	typedef logic [STEP_IDX_W-1:0] step_idx_t;

	localparam int TABLE_LEN = 8;
	localparam int TBL_IDX_W = $clog2(TABLE_LEN);
	typedef logic [TBL_IDX_W-1:0] tbl_idx_t;

	localparam int MULTI_LEN = 2;
	localparam int MULTI_IDX_W = $clog2(MULTI_LEN);
	typedef logic [MULTI_IDX_W-1:0] multi_idx_t;

	localparam byte_t VHV_2V8_MASK = 8'h01;
	// msrc (bit 1) and pre-range (bit 4) limit checks off
	localparam byte_t MSRC_LIMIT_CHECK_MASK = 8'h12;

	////////////////////
	// data init steps
	////////////////////
	localparam step_t STEP_LIST [STEP_COUNT] = '{
		'{STEP_MODIFY, VHV_CONFIG_PAD_SCL_SDA_EXTSUP_HV, VHV_2V8_MASK, 4'd1},
		'{STEP_TABLE, I2C_MODE_CTRL, 8'd0, 4'd4},
		'{STEP_CAPTURE, STOP_VARIABLE_SRC, STOP_VARIABLE, 4'd1},
		'{STEP_TABLE, SYSRANGE_START, 8'd4, 4'd3},
		'{STEP_MODIFY, MSRC_CONFIG_CONTROL, MSRC_LIMIT_CHECK_MASK, 4'd1},
		'{STEP_MULTI, FINAL_RANGE_CONFIG_MIN_COUNT_RATE_RTN_LIMIT, 8'd0, 4'd2},
		'{STEP_TABLE, SYSTEM_SEQUENCE_CONFIG, 8'd7, 4'd1}
	};

	// single byte writes, addressed by table steps
	localparam table_entry_t WRITE_TABLE [TABLE_LEN] = '{
		'{I2C_MODE_CTRL, 8'h00},
		'{POWER_MANAGEMENT_GO1_POWER_FORCE, 8'h01},
		'{PAGE_SELECT, 8'h01},
		'{SYSRANGE_START, 8'h00},
		'{SYSRANGE_START, 8'h01},
		'{PAGE_SELECT, 8'h00},
		'{POWER_MANAGEMENT_GO1_POWER_FORCE, 8'h00},
		'{SYSTEM_SEQUENCE_CONFIG, 8'hFF}
	};

	// 0x0020 is a rate limit of 0.25 MCPS
	localparam byte_t MULTI_BYTES [MULTI_LEN] = '{8'h00, 8'h20};

endpackage

/* src/init_sequencer.sv */
`timescale 1ns/10ps

module init_sequencer import init_seq_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  start,
	input  logic  comm_error,
	output logic  done,
	output step_t step,
	output logic  rb_go,
	output logic  tw_go,
	output logic  mw_go,
	input  logic  rb_finished,
	input  logic  tw_finished,
	input  logic  mw_finished
);

	typedef enum logic {S_IDLE, S_RUN} state_t;

	state_t state;
	step_idx_t step_idx;
	step_idx_t launch_idx;
	step_kind_t launch_kind;
	logic any_finished;
	logic last_step;
	logic launch;

	assign step = STEP_LIST[step_idx];

	// only one engine runs at a time
	assign any_finished = rb_finished || tw_finished || mw_finished;
	assign last_step = (step_idx == step_idx_t'(STEP_COUNT - 1));

	// start launches step 0, each finish launches the next one
	assign launch = (state == S_IDLE) ? start : (any_finished && !last_step);
	assign launch_idx = (state == S_IDLE) ? '0 : step_idx + step_idx_t'(1);
	assign launch_kind = STEP_LIST[launch_idx].kind;

	always_ff @(posedge clk) begin
		if (reset || comm_error) begin
			state <= S_IDLE;
			step_idx <= '0;
			done <= 1'b0;
			rb_go <= 1'b0;
			tw_go <= 1'b0;
			mw_go <= 1'b0;
		end else begin
			rb_go <= launch && (launch_kind == STEP_MODIFY || launch_kind == STEP_CAPTURE);
			tw_go <= launch && (launch_kind == STEP_TABLE);
			mw_go <= launch && (launch_kind == STEP_MULTI);
			if (launch) begin
				step_idx <= launch_idx;
			end
			if (state == S_IDLE && start) begin
				state <= S_RUN;
				done <= 1'b0;
			end else if (state == S_RUN && any_finished && last_step) begin
				// done holds until the next start
				state <= S_IDLE;
				done <= 1'b1;
			end
		end
	end

	a_go_onehot: assert property (@(posedge clk) disable iff (reset)
		(rb_go || tw_go || mw_go) |-> $onehot({rb_go, tw_go, mw_go}) && $past(launch))
		else $error("go pulses not one-hot or not launched");

endmodule

/* src/read_back_engine.sv */
`timescale 1ns/10ps

module read_back_engine import vl53_regs_pkg::*, init_seq_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      comm_error,
	input  logic      go,
	input  step_t     step,
	output logic      finished,
	output logic      req,
	output fnc_t      fnc,
	output reg_addr_t reg_addr,
	output byte_t     data,
	output n_bytes_t  n_bytes,
	input  logic      cmd_done,
	input  byte_t     fifo_data_in,
	input  logic      fifo_read_valid,
	output logic      fifo_read_en,
	output ram_addr_t ram_addr,
	output byte_t     ram_data_out,
	output logic      ram_wr_en
);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_FETCH, S_WRITE} state_t;

	state_t state;

	// read first, write back to the same register in modify mode
	assign req = (state == S_READ) || (state == S_WRITE);
	assign fnc = (state == S_WRITE) ? FNC_WRITE : FNC_READ;
	assign reg_addr = step.reg_addr;
	assign n_bytes = step.count;

	always_ff @(posedge clk) begin
		if (reset || comm_error) begin
			state <= S_IDLE;
			finished <= 1'b0;
			fifo_read_en <= 1'b0;
			ram_wr_en <= 1'b0;
		end else begin
			finished <= 1'b0;
			fifo_read_en <= 1'b0;
			ram_wr_en <= 1'b0;
			case (state)
				S_IDLE: begin
					if (go) begin
						state <= S_READ;
					end
				end
				S_READ: begin
					if (cmd_done) begin
						fifo_read_en <= 1'b1;
						state <= S_FETCH;
					end
				end
				S_FETCH: begin
					if (fifo_read_valid && step.kind == STEP_MODIFY) begin
						state <= S_WRITE;
					end else if (fifo_read_valid) begin
						// capture ends with the ram write
						ram_wr_en <= 1'b1;
						finished <= 1'b1;
						state <= S_IDLE;
					end
				end
				S_WRITE: begin
					if (cmd_done) begin
						finished <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_FETCH && fifo_read_valid) begin
			data <= fifo_data_in | step.arg;
			ram_addr <= step.arg;
			ram_data_out <= fifo_data_in;
		end
	end

	a_fetch_en: assert property (@(posedge clk) disable iff (reset)
		fifo_read_en |-> state == S_FETCH && $past(cmd_done) && $past(state) == S_READ)
		else $error("fifo_read_en outside the fetch after a read");

endmodule

/* src/table_writer.sv */
`timescale 1ns/10ps

module table_writer import vl53_regs_pkg::*, init_seq_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      comm_error,
	input  logic      go,
	input  step_t     step,
	output logic      finished,
	output logic      req,
	output fnc_t      fnc,
	output reg_addr_t reg_addr,
	output byte_t     data,
	output n_bytes_t  n_bytes,
	input  logic      cmd_done
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_NEXT} state_t;

	state_t state;
	tbl_idx_t idx;
	n_bytes_t left;

	assign req = (state == S_REQ);
	assign fnc = FNC_WRITE;
	assign reg_addr = WRITE_TABLE[idx].addr;
	assign data = WRITE_TABLE[idx].data;
	assign n_bytes = n_bytes_t'(1);

	always_ff @(posedge clk) begin
		if (reset || comm_error) begin
			state <= S_IDLE;
			finished <= 1'b0;
			idx <= '0;
			left <= '0;
		end else begin
			finished <= 1'b0;
			case (state)
				S_IDLE: begin
					if (go) begin
						idx <= step.arg[TBL_IDX_W-1:0];
						left <= step.count;
						state <= S_REQ;
					end
				end
				S_REQ: begin
					if (cmd_done && left == n_bytes_t'(1)) begin
						finished <= 1'b1;
						state <= S_IDLE;
					end else if (cmd_done) begin
						idx <= idx + tbl_idx_t'(1);
						left <= left - n_bytes_t'(1);
						state <= S_NEXT;
					end
				end
				// req low for a cycle between entries
				S_NEXT: state <= S_REQ;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* src/multi_writer.sv */
`timescale 1ns/10ps

module multi_writer import vl53_regs_pkg::*, init_seq_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      comm_error,
	input  logic      go,
	input  step_t     step,
	output logic      finished,
	output logic      req,
	output fnc_t      fnc,
	output reg_addr_t reg_addr,
	output byte_t     data,
	output n_bytes_t  n_bytes,
	input  logic      cmd_done,
	output logic      fifo_wr_en,
	output byte_t     fifo_data_out,
	input  logic      fifo_write_ack
);

	typedef enum logic [1:0] {S_IDLE, S_PUSH, S_REQ} state_t;

	state_t state;
	multi_idx_t byte_idx;

	assign fifo_data_out = MULTI_BYTES[byte_idx];

	// payload goes through the write fifo, data is unused here
	assign req = (state == S_REQ);
	assign fnc = FNC_WRITE_MULTI;
	assign reg_addr = step.reg_addr;
	assign data = '0;
	assign n_bytes = step.count;

	always_ff @(posedge clk) begin
		if (reset || comm_error) begin
			state <= S_IDLE;
			finished <= 1'b0;
			fifo_wr_en <= 1'b0;
			byte_idx <= '0;
		end else begin
			finished <= 1'b0;
			fifo_wr_en <= 1'b0;
			case (state)
				S_IDLE: begin
					if (go) begin
						byte_idx <= '0;
						fifo_wr_en <= 1'b1;
						state <= S_PUSH;
					end
				end
				S_PUSH: begin
					// one byte in flight, next push after its ack
					if (fifo_write_ack && n_bytes_t'(byte_idx) + n_bytes_t'(1) == step.count) begin
						state <= S_REQ;
					end else if (fifo_write_ack) begin
						byte_idx <= byte_idx + multi_idx_t'(1);
						fifo_wr_en <= 1'b1;
					end
				end
				S_REQ: begin
					if (cmd_done) begin
						finished <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* src/i2c_cmd_arbiter.sv */
`timescale 1ns/10ps

module i2c_cmd_arbiter import vl53_regs_pkg::*, init_seq_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      comm_error,
	input  logic      rb_req,
	input  fnc_t      rb_fnc,
	input  reg_addr_t rb_reg,
	input  byte_t     rb_data,
	input  n_bytes_t  rb_n_bytes,
	input  logic      tw_req,
	input  fnc_t      tw_fnc,
	input  reg_addr_t tw_reg,
	input  byte_t     tw_data,
	input  n_bytes_t  tw_n_bytes,
	input  logic      mw_req,
	input  fnc_t      mw_fnc,
	input  reg_addr_t mw_reg,
	input  byte_t     mw_data,
	input  n_bytes_t  mw_n_bytes,
	output logic      rb_cmd_done,
	output logic      tw_cmd_done,
	output logic      mw_cmd_done,
	output logic      write_start,
	output logic      read_start,
	output logic      write_multi_start,
	output fnc_t      fnc_sel,
	output reg_addr_t reg_address_out,
	output byte_t     data_out,
	output n_bytes_t  n_bytes,
	input  logic      write_done,
	input  logic      read_done,
	input  logic      write_multi_done
);

	// bit 0 read-back, bit 1 table, bit 2 multi
	logic [2:0] grant;
	logic [2:0] pick;
	logic launched;
	logic gap;
	logic idle;
	logic bus_done;

	assign idle = (grant == '0) && !gap;

	// fixed priority
	always_comb begin
		pick = 3'b000;
		if (rb_req) begin
			pick = 3'b001;
		end else if (tw_req) begin
			pick = 3'b010;
		end else if (mw_req) begin
			pick = 3'b100;
		end
	end

	assign bus_done = launched && ((fnc_sel == FNC_READ && read_done) ||
		(fnc_sel == FNC_WRITE && write_done) ||
		(fnc_sel == FNC_WRITE_MULTI && write_multi_done));

	assign rb_cmd_done = bus_done && grant[0];
	assign tw_cmd_done = bus_done && grant[1];
	assign mw_cmd_done = bus_done && grant[2];

	////////////////////
	// grant and strobe
	////////////////////
	always_ff @(posedge clk) begin
		if (reset || comm_error) begin
			grant <= '0;
			launched <= 1'b0;
			gap <= 1'b0;
			write_start <= 1'b0;
			read_start <= 1'b0;
			write_multi_start <= 1'b0;
		end else begin
			write_start <= 1'b0;
			read_start <= 1'b0;
			write_multi_start <= 1'b0;
			gap <= 1'b0;
			if (idle) begin
				grant <= pick;
			end else if (grant != '0 && !launched) begin
				launched <= 1'b1;
				read_start <= (fnc_sel == FNC_READ);
				write_start <= (fnc_sel == FNC_WRITE);
				write_multi_start <= (fnc_sel == FNC_WRITE_MULTI);
			end else if (bus_done) begin
				// one idle cycle follows every transaction
				grant <= '0;
				launched <= 1'b0;
				gap <= 1'b1;
			end
		end
	end

	// command held from grant to done
	always_ff @(posedge clk) begin
		if (idle && pick[0]) begin
			fnc_sel <= rb_fnc;
			reg_address_out <= rb_reg;
			data_out <= rb_data;
			n_bytes <= rb_n_bytes;
		end else if (idle && pick[1]) begin
			fnc_sel <= tw_fnc;
			reg_address_out <= tw_reg;
			data_out <= tw_data;
			n_bytes <= tw_n_bytes;
		end else if (idle && pick[2]) begin
			fnc_sel <= mw_fnc;
			reg_address_out <= mw_reg;
			data_out <= mw_data;
			n_bytes <= mw_n_bytes;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant))
		else $error("grant not one-hot: %b", grant);

	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		(write_start || read_start || write_multi_start) |->
		$onehot({write_start, read_start, write_multi_start}) && grant != '0 && $stable(grant))
		else $error("start strobe without a held grant");

endmodule

/* src/vl53_data_init.sv */
`timescale 1ns/10ps

module vl53_data_init import vl53_regs_pkg::*, init_seq_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  logic      comm_error,
	output logic      done,
	output logic      write_start,
	input  logic      write_done,
	output logic      write_multi_start,
	input  logic      write_multi_done,
	output logic      read_start,
	input  logic      read_done,
	output reg_addr_t reg_address_out,
	output byte_t     data_out,
	output n_bytes_t  n_bytes,
	output fnc_t      fnc_sel,
	input  byte_t     fifo_data_in,
	output logic      fifo_read_en,
	input  logic      fifo_read_valid,
	output byte_t     fifo_data_out,
	output logic      fifo_wr_en,
	input  logic      fifo_write_ack,
	output ram_addr_t ram_addr,
	output byte_t     ram_data_out,
	output logic      ram_wr_en
);

	step_t step;
	logic rb_go, tw_go, mw_go;
	logic rb_finished, tw_finished, mw_finished;
	logic rb_cmd_done, tw_cmd_done, mw_cmd_done;

	// engine requests towards the arbiter
	logic rb_req, tw_req, mw_req;
	fnc_t rb_fnc, tw_fnc, mw_fnc;
	reg_addr_t rb_reg, tw_reg, mw_reg;
	byte_t rb_data, tw_data, mw_data;
	n_bytes_t rb_n_bytes, tw_n_bytes, mw_n_bytes;

	init_sequencer i_init_sequencer (
		.clk(clk), .reset(reset), .start(start), .comm_error(comm_error),
		.done(done), .step(step),
		.rb_go(rb_go), .tw_go(tw_go), .mw_go(mw_go),
		.rb_finished(rb_finished), .tw_finished(tw_finished), .mw_finished(mw_finished)
	);

	read_back_engine i_read_back_engine (
		.clk(clk), .reset(reset), .comm_error(comm_error),
		.go(rb_go), .step(step), .finished(rb_finished),
		.req(rb_req), .fnc(rb_fnc), .reg_addr(rb_reg), .data(rb_data), .n_bytes(rb_n_bytes),
		.cmd_done(rb_cmd_done),
		.fifo_data_in(fifo_data_in), .fifo_read_valid(fifo_read_valid),
		.fifo_read_en(fifo_read_en),
		.ram_addr(ram_addr), .ram_data_out(ram_data_out), .ram_wr_en(ram_wr_en)
	);

	table_writer i_table_writer (
		.clk(clk), .reset(reset), .comm_error(comm_error),
		.go(tw_go), .step(step), .finished(tw_finished),
		.req(tw_req), .fnc(tw_fnc), .reg_addr(tw_reg), .data(tw_data), .n_bytes(tw_n_bytes),
		.cmd_done(tw_cmd_done)
	);

	multi_writer i_multi_writer (
		.clk(clk), .reset(reset), .comm_error(comm_error),
		.go(mw_go), .step(step), .finished(mw_finished),
		.req(mw_req), .fnc(mw_fnc), .reg_addr(mw_reg), .data(mw_data), .n_bytes(mw_n_bytes),
		.cmd_done(mw_cmd_done),
		.fifo_wr_en(fifo_wr_en), .fifo_data_out(fifo_data_out), .fifo_write_ack(fifo_write_ack)
	);

	i2c_cmd_arbiter i_i2c_cmd_arbiter (
		.clk(clk), .reset(reset), .comm_error(comm_error),
		.rb_req(rb_req), .rb_fnc(rb_fnc), .rb_reg(rb_reg),
		.rb_data(rb_data), .rb_n_bytes(rb_n_bytes),
		.tw_req(tw_req), .tw_fnc(tw_fnc), .tw_reg(tw_reg),
		.tw_data(tw_data), .tw_n_bytes(tw_n_bytes),
		.mw_req(mw_req), .mw_fnc(mw_fnc), .mw_reg(mw_reg),
		.mw_data(mw_data), .mw_n_bytes(mw_n_bytes),
		.rb_cmd_done(rb_cmd_done), .tw_cmd_done(tw_cmd_done), .mw_cmd_done(mw_cmd_done),
		.write_start(write_start), .read_start(read_start),
		.write_multi_start(write_multi_start),
		.fnc_sel(fnc_sel), .reg_address_out(reg_address_out),
		.data_out(data_out), .n_bytes(n_bytes),
		.write_done(write_done), .read_done(read_done), .write_multi_done(write_multi_done)
	);

endmodule

/* tests/i2c_target_model.sv */
`timescale 1ns/10ps

module i2c_target_model import vl53_regs_pkg::*, init_seq_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      comm_error,
	input  logic      write_start,
	input  logic      read_start,
	input  logic      write_multi_start,
	output logic      write_done,
	output logic      read_done,
	output logic      write_multi_done,
	input  reg_addr_t reg_address_out,
	input  byte_t     data_out,
	input  n_bytes_t  n_bytes,
	input  logic      fifo_read_en,
	output logic      fifo_read_valid,
	output byte_t     fifo_data_in,
	input  logic      fifo_wr_en,
	input  byte_t     fifo_data_out,
	output logic      fifo_write_ack,
	input  ram_addr_t ram_addr,
	input  byte_t     ram_data_out,
	input  logic      ram_wr_en
);

	// sensor register image and host ram
	byte_t regs [256];
	byte_t ram [256];
	byte_t read_fifo [$];
	byte_t write_fifo [$];
	integer seed;
	logic busy;
	int wait_cnt;
	// bit 0 read, bit 1 write, bit 2 multi-write
	logic [2:0] cmd_kind;
	reg_addr_t cmd_reg;
	byte_t cmd_data;
	n_bytes_t cmd_n;

	initial begin
		seed = 68056;
		for (int a = 0; a < 256; a++) begin
			regs[a] = 8'(a * 7 + 3);
			ram[a] = 8'(a ^ 8'hA5);
		end
		// registers the sequence reads back
		regs[8'h89] = 8'($random(seed));
		regs[8'h60] = 8'($random(seed));
		regs[8'h91] = 8'($random(seed));
		write_done = 1'b0;
		read_done = 1'b0;
		write_multi_done = 1'b0;
		fifo_read_valid = 1'b0;
		fifo_data_in = 8'h00;
		fifo_write_ack = 1'b0;
		busy = 1'b0;
		wait_cnt = 0;
		cmd_kind = 3'b000;
	end

	always @(posedge clk) begin
		write_done <= 1'b0;
		read_done <= 1'b0;
		write_multi_done <= 1'b0;
		fifo_read_valid <= 1'b0;
		fifo_write_ack <= 1'b0;
		if (reset || comm_error) begin
			// an aborted transfer never completes
			busy <= 1'b0;
			read_fifo.delete();
			write_fifo.delete();
		end else begin
			if (read_start || write_start || write_multi_start) begin
				busy <= 1'b1;
				wait_cnt <= 1 + int'($unsigned($random(seed)) % 8);
				cmd_kind <= {write_multi_start, write_start, read_start};
				cmd_reg <= reg_address_out;
				cmd_data <= data_out;
				cmd_n <= n_bytes;
			end else if (busy && wait_cnt > 1) begin
				wait_cnt <= wait_cnt - 1;
			end else if (busy) begin
				busy <= 1'b0;
				if (cmd_kind[0]) begin
					read_fifo.push_back(regs[cmd_reg]);
					read_done <= 1'b1;
				end else if (cmd_kind[1]) begin
					regs[cmd_reg] = cmd_data;
					write_done <= 1'b1;
				end else begin
					// auto-increment across consecutive registers
					for (int i = 0; i < int'(cmd_n); i++) begin
						if (write_fifo.size() > 0) begin
							regs[8'(int'(cmd_reg) + i)] = write_fifo.pop_front();
						end
					end
					write_multi_done <= 1'b1;
				end
			end
			if (fifo_read_en && read_fifo.size() > 0) begin
				fifo_data_in <= read_fifo.pop_front();
				fifo_read_valid <= 1'b1;
			end
			if (fifo_wr_en) begin
				write_fifo.push_back(fifo_data_out);
				fifo_write_ack <= 1'b1;
			end
			if (ram_wr_en) begin
				ram[ram_addr] = ram_data_out;
			end
		end
	end

endmodule

/* tests/tb_vl53_data_init.sv */
`timescale 1ns/10ps

module tb_vl53_data_init import vl53_regs_pkg::*, init_seq_pkg::*; ();

	localparam int TXN_COUNT = 14;
	localparam int READ_COUNT = 3;
	localparam int WAIT_LIMIT = 4000;
	localparam byte_t EXP_FIFO_BYTES [2] = '{8'h00, 8'h20};

	logic clk;
	logic reset;
	logic start;
	logic comm_error;
	logic done;
	logic write_start, write_done;
	logic write_multi_start, write_multi_done;
	logic read_start, read_done;
	reg_addr_t reg_address_out;
	byte_t data_out;
	n_bytes_t n_bytes;
	fnc_t fnc_sel;
	byte_t fifo_data_in;
	logic fifo_read_en, fifo_read_valid;
	byte_t fifo_data_out;
	logic fifo_wr_en, fifo_write_ack;
	ram_addr_t ram_addr;
	byte_t ram_data_out;
	logic ram_wr_en;

	// expected transactions of one run, code 1 read, 2 write, 3 multi-write
	logic [1:0] exp_fnc [TXN_COUNT];
	reg_addr_t exp_reg [TXN_COUNT];
	byte_t exp_data [TXN_COUNT];
	byte_t exp_stop;

	int txn_idx;
	int wr_seen;
	int rd_seen;
	int ram_count;
	int total_txn = 0;
	int runs_done = 0;
	int error_count = 0;
	logic pending;
	logic quiet;
	logic hold_done;
	logic done_q;

	vl53_data_init i_vl53_data_init (
		.clk(clk), .reset(reset), .start(start), .comm_error(comm_error), .done(done),
		.write_start(write_start), .write_done(write_done),
		.write_multi_start(write_multi_start), .write_multi_done(write_multi_done),
		.read_start(read_start), .read_done(read_done),
		.reg_address_out(reg_address_out), .data_out(data_out),
		.n_bytes(n_bytes), .fnc_sel(fnc_sel),
		.fifo_data_in(fifo_data_in), .fifo_read_en(fifo_read_en),
		.fifo_read_valid(fifo_read_valid),
		.fifo_data_out(fifo_data_out), .fifo_wr_en(fifo_wr_en),
		.fifo_write_ack(fifo_write_ack),
		.ram_addr(ram_addr), .ram_data_out(ram_data_out), .ram_wr_en(ram_wr_en)
	);

	i2c_target_model i_model (
		.clk(clk), .reset(reset), .comm_error(comm_error),
		.write_start(write_start), .read_start(read_start),
		.write_multi_start(write_multi_start),
		.write_done(write_done), .read_done(read_done), .write_multi_done(write_multi_done),
		.reg_address_out(reg_address_out), .data_out(data_out), .n_bytes(n_bytes),
		.fifo_read_en(fifo_read_en), .fifo_read_valid(fifo_read_valid),
		.fifo_data_in(fifo_data_in),
		.fifo_wr_en(fifo_wr_en), .fifo_data_out(fifo_data_out),
		.fifo_write_ack(fifo_write_ack),
		.ram_addr(ram_addr), .ram_data_out(ram_data_out), .ram_wr_en(ram_wr_en)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic log_mismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
		error_count++;
		$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
	endtask

	task automatic note_failure(input string msg);
		error_count++;
		$display("error: %s", msg);
	endtask

	task automatic print_counts();
		$display("errors: %0d, transactions: %0d, completed runs: %0d",
			error_count, total_txn, runs_done);
	endtask

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		print_counts();
		$display("TESTS FAILED");
		$finish;
	endtask

	function void set_txn(input int i, input logic [1:0] f, input byte_t r, input byte_t d);
		exp_fnc[i] = f;
		exp_reg[i] = r;
		exp_data[i] = d;
	endfunction

	////////////////////
	// expected sequence
	////////////////////
	task automatic load_expected();
		byte_t pad;
		byte_t msrc;
		pad = i_model.regs[8'h89];
		msrc = i_model.regs[8'h60];
		exp_stop = i_model.regs[8'h91];
		set_txn(0, 2'd1, 8'h89, 8'h00);
		set_txn(1, 2'd2, 8'h89, pad | 8'h01);
		set_txn(2, 2'd2, 8'h88, 8'h00);
		set_txn(3, 2'd2, 8'h80, 8'h01);
		set_txn(4, 2'd2, 8'hFF, 8'h01);
		set_txn(5, 2'd2, 8'h00, 8'h00);
		set_txn(6, 2'd1, 8'h91, 8'h00);
		set_txn(7, 2'd2, 8'h00, 8'h01);
		set_txn(8, 2'd2, 8'hFF, 8'h00);
		set_txn(9, 2'd2, 8'h80, 8'h00);
		set_txn(10, 2'd1, 8'h60, 8'h00);
		set_txn(11, 2'd2, 8'h60, msrc | 8'h12);
		set_txn(12, 2'd3, 8'h44, 8'h00);
		set_txn(13, 2'd2, 8'h01, 8'hFF);
	endtask

	// returns once the old done has cleared
	task automatic pulse_start();
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		@(posedge clk);
	endtask

	task automatic wait_for_done(input int limit);
		int cycles;
		cycles = 0;
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (!done) begin
			give_up("done");
		end
	endtask

	task automatic await_txn_count(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (txn_idx < count && cycles < limit) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (txn_idx < count) begin
			give_up("the transaction count");
		end
	endtask

	////////////////////
	// bus monitor
	////////////////////
	always @(posedge clk) begin
		logic any_start;
		logic [1:0] code;
		any_start = read_start || write_start || write_multi_start;
		code = write_multi_start ? 2'd3 : (write_start ? 2'd2 : 2'd1);
		if (reset) begin
			pending <= 1'b0;
			quiet <= 1'b1;
			hold_done <= 1'b0;
			done_q <= 1'b0;
			txn_idx <= 0;
			wr_seen <= 0;
			rd_seen <= 0;
			ram_count <= 0;
		end else begin
			if (quiet) begin
				assert (!(any_start || fifo_read_en || fifo_wr_en || ram_wr_en || done))
					else note_failure("strobe, enable or done high while the sequencer is idle");
			end
			if (any_start) begin
				assert (!pending)
					else note_failure("start strobe while a transaction awaits its done");
				assert (txn_idx < TXN_COUNT)
					else note_failure("more transactions than the sequence holds");
				if (txn_idx < TXN_COUNT) begin
					assert (code == exp_fnc[txn_idx])
						else log_mismatch("start strobe kind", 8'(code), 8'(exp_fnc[txn_idx]));
					assert (fnc_sel == exp_fnc[txn_idx])
						else log_mismatch("fnc_sel", 8'(fnc_sel), 8'(exp_fnc[txn_idx]));
					assert (reg_address_out == exp_reg[txn_idx])
						else log_mismatch("reg_address_out", reg_address_out, exp_reg[txn_idx]);
					if (exp_fnc[txn_idx] == 2'd2) begin
						assert (data_out == exp_data[txn_idx])
							else log_mismatch("data_out", data_out, exp_data[txn_idx]);
					end
					if (exp_fnc[txn_idx] == 2'd3) begin
						assert (n_bytes == 4'd2)
							else log_mismatch("n_bytes", 8'(n_bytes), 8'h02);
						assert (wr_seen == 2)
							else note_failure("multi-write started before both FIFO bytes");
					end
				end
				txn_idx <= txn_idx + 1;
				total_txn <= total_txn + 1;
				pending <= 1'b1;
			end else if (read_done || write_done || write_multi_done) begin
				pending <= 1'b0;
			end
			if (fifo_wr_en) begin
				assert (wr_seen < 2)
					else note_failure("more than two bytes pushed to the write FIFO");
				if (wr_seen < 2) begin
					assert (fifo_data_out == EXP_FIFO_BYTES[wr_seen])
						else log_mismatch("fifo_data_out", fifo_data_out, EXP_FIFO_BYTES[wr_seen]);
				end
				wr_seen <= wr_seen + 1;
			end
			if (fifo_read_en) begin
				rd_seen <= rd_seen + 1;
			end
			if (ram_wr_en) begin
				assert (ram_addr == 8'h00)
					else log_mismatch("ram_addr", ram_addr, 8'h00);
				assert (ram_data_out == exp_stop)
					else log_mismatch("ram_data_out", ram_data_out, exp_stop);
				ram_count <= ram_count + 1;
			end
			if (done && !done_q) begin
				assert (txn_idx == TXN_COUNT)
					else note_failure("done rose before the last transaction");
				assert (!pending)
					else note_failure("done rose while a transaction awaits its done");
				assert (ram_count == 1)
					else note_failure("stop variable not stored exactly once");
				assert (rd_seen == READ_COUNT)
					else log_mismatch("fifo_read_en count", 8'(rd_seen), 8'(READ_COUNT));
				assert (i_model.ram[8'h00] == exp_stop)
					else log_mismatch("ram[STOP_VARIABLE]", i_model.ram[8'h00], exp_stop);
				hold_done <= 1'b1;
				runs_done <= runs_done + 1;
			end
			if (hold_done) begin
				assert (done)
					else note_failure("done dropped before the next start");
			end
			done_q <= done;
			// new run
			if (start) begin
				quiet <= 1'b0;
				hold_done <= 1'b0;
				txn_idx <= 0;
				wr_seen <= 0;
				rd_seen <= 0;
				ram_count <= 0;
			end
			if (comm_error) begin
				quiet <= 1'b1;
				hold_done <= 1'b0;
				pending <= 1'b0;
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////
	initial begin
		reset = 1'b1;
		start = 1'b0;
		comm_error = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		// idle until the first start
		repeat (10) @(posedge clk);
		load_expected();
		pulse_start();
		wait_for_done(WAIT_LIMIT);
		repeat (10) @(posedge clk);

		// abort after the first table run
		load_expected();
		pulse_start();
		await_txn_count(6, WAIT_LIMIT);
		comm_error <= 1'b1;
		@(posedge clk);
		comm_error <= 1'b0;
		repeat (20) @(posedge clk);

		// full rerun after the abort
		load_expected();
		pulse_start();
		wait_for_done(WAIT_LIMIT);
		repeat (10) @(posedge clk);

		print_counts();
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
src/vl53_regs_pkg.sv
src/init_seq_pkg.sv
src/init_sequencer.sv
src/read_back_engine.sv
src/table_writer.sv
src/multi_writer.sv
src/i2c_cmd_arbiter.sv
src/vl53_data_init.sv
tests/i2c_target_model.sv
tests/tb_vl53_data_init.sv

/* Bender.yml */
package:
  name: vl53_data_init

sources:
  - src/vl53_regs_pkg.sv
  - src/init_seq_pkg.sv
  - src/init_sequencer.sv
  - src/read_back_engine.sv
  - src/table_writer.sv
  - src/multi_writer.sv
  - src/i2c_cmd_arbiter.sv
  - src/vl53_data_init.sv
  - target: test
    files:
      - tests/i2c_target_model.sv
      - tests/tb_vl53_data_init.sv
